//--- include/rv_cfg.svh
// Core configuration macros for widths, memory sizes and the reset PC
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// ==============================
// Datapath and register file
// ==============================
`define RV_XLEN      32             // Data and address width
`define RV_REG_COUNT 32             // Architectural registers
`define RV_REG_AW    5              // Register index width

// ==============================
// Memories
// ==============================
`define RV_IMEM_AW   8              // Instruction memory word address bits
`define RV_DMEM_AW   8              // Data memory word address bits
`define RV_RESET_PC  32'h0000_0000  // First fetch address

`endif

//--- design/rv_isa_pkg.sv
// RV32I subset instruction set types shared by decode, execute and the testbench
package rv_isa_pkg;

    // ==============================
    // Major opcodes
    // ==============================
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,    // Register-register ALU
        OPC_OP_IMM = 7'b0010011,    // Register-immediate ALU
        OPC_LOAD   = 7'b0000011,    // LW
        OPC_STORE  = 7'b0100011,    // SW
        OPC_BRANCH = 7'b1100011,    // BEQ, BNE
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // ALU operations seen by execute
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT                     // Signed compare
    } alu_op_e;

    // ==============================
    // Function fields
    // ==============================
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_WORD    = 3'b010;    // LW and SW width
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [6:0] F7_SUB     = 7'b0100000; // Selects SUB over ADD

endpackage

//--- design/rv_pipe_pkg.sv
// Pipeline stage register, forwarding, program load and retire types
`include "rv_cfg.svh"

package rv_pipe_pkg;
    import rv_isa_pkg::*;

    // ==============================
    // Stage registers
    // ==============================
    typedef struct packed {
        logic [`RV_XLEN-1:0]   instr;       // Zero word is a bubble
        logic [`RV_XLEN-1:0]   pc;
    } if_id_t;

    typedef struct packed {
        logic                  reg_write;
        logic                  mem_read;    // LW
        logic                  mem_write;   // SW
        logic                  alu_src;     // Immediate as operand B
        logic                  branch;
        logic                  bne;         // Branch on not equal
        logic                  jump;        // JAL
        alu_op_e               alu_op;
        logic [`RV_XLEN-1:0]   rs1_data;
        logic [`RV_XLEN-1:0]   rs2_data;
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   imm;         // Sign extended I, S, B or J
        logic [`RV_XLEN-1:0]   pc;
    } id_ex_t;

    typedef struct packed {
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   result;      // ALU result, address or link
        logic [`RV_XLEN-1:0]   store_data;  // Forwarded rs2
    } ex_mem_t;

    typedef struct packed {
        logic                  reg_write;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   result;      // Load data or ALU result
    } mem_wb_t;

    // Operand source in execute
    typedef enum logic [1:0] {
        FWD_REGFILE,
        FWD_FROM_MEM,               // EX/MEM result
        FWD_FROM_WB                 // MEM/WB result
    } fwd_sel_e;

    // ==============================
    // Top-level ports
    // ==============================
    typedef struct packed {
        logic                   we;
        logic [`RV_IMEM_AW-1:0] addr;      // Word address
        logic [`RV_XLEN-1:0]    instr;
    } prog_wr_t;

    typedef struct packed {
        logic                  valid;       // One per nonzero rd write
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   data;
    } retire_t;

endpackage

//--- design/rv_fetch.sv
// Fetch stage with program counter, loadable instruction memory and IF/ID register
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_fetch
    import rv_pipe_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,
    input  logic                run,        // Low while a program is loaded
    input  prog_wr_t            prog,       // Program write port
    input  logic                stall,      // Load-use hold from decode
    input  logic                redirect,   // Taken branch or jump in execute
    input  logic [`RV_XLEN-1:0] target,
    output if_id_t              if_id
);

    logic [`RV_XLEN-1:0] imem [2**`RV_IMEM_AW];  // Word addressed
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] instr;                 // Word at the current PC

    // ==============================
    // Instruction memory
    // ==============================
    always_ff @(posedge clk) begin
        if (prog.we)
            imem[prog.addr] <= prog.instr;
    end

    assign instr = imem[pc[`RV_IMEM_AW+1:2]];   // Combinational read

    // ==============================
    // Program counter
    // ==============================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            pc <= `RV_RESET_PC;
        else if (!run)
            pc <= `RV_RESET_PC;                 // Parked during load
        else if (redirect)
            pc <= target;                       // Never coincides with stall
        else if (!stall)
            pc <= pc + 'd4;
    end

    // ==============================
    // IF/ID register
    // ==============================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            if_id <= '0;
        else if (!run || redirect)
            if_id <= '0;                        // Bubble, zero word has no control
        else if (!stall)
            if_id <= '{instr: instr, pc: pc};
    end

endmodule

//--- design/rv_decode.sv
// Decode stage with register file, load-use hazard detection and ID/EX register
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_decode
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  if_id_t  if_id,
    input  logic    redirect,           // Squash the instruction in IF/ID
    input  mem_wb_t mem_wb,             // Register file write port
    output logic    stall,              // Load-use hold for fetch
    output id_ex_t  id_ex
);

    logic [`RV_XLEN-1:0]   regs [`RV_REG_COUNT];   // x0 never written
    logic [`RV_XLEN-1:0]   instr;
    opcode_e               opcode;
    logic [`RV_REG_AW-1:0] rs1;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_XLEN-1:0]   imm_i;
    logic [`RV_XLEN-1:0]   imm_s;
    logic [`RV_XLEN-1:0]   imm_b;
    logic [`RV_XLEN-1:0]   imm_j;
    logic                  use_rs1;        // Instruction reads rs1
    logic                  use_rs2;        // Instruction reads rs2
    id_ex_t                nxt;            // Next ID/EX contents

    assign instr  = if_id.instr;
    assign opcode = opcode_e'(instr[6:0]);
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // Immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    // ==============================
    // Register file
    // ==============================
    always_ff @(posedge clk) begin
        if (mem_wb.reg_write && mem_wb.rd != '0)
            regs[mem_wb.rd] <= mem_wb.result;
    end

    function automatic logic [`RV_XLEN-1:0] rf_read(input logic [`RV_REG_AW-1:0] idx);
        if (idx == '0)
            return '0;                          // x0 reads as zero
        if (mem_wb.reg_write && mem_wb.rd == idx)
            return mem_wb.result;               // Same-cycle write-through
        return regs[idx];
    endfunction

    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic sub);
        case (f3)
            F3_ADD_SUB: return sub ? ALU_SUB : ALU_ADD;
            F3_SLT:     return ALU_SLT;
            F3_XOR:     return ALU_XOR;
            F3_OR:      return ALU_OR;
            F3_AND:     return ALU_AND;
            default:    return ALU_ADD;
        endcase
    endfunction

    // ==============================
    // Control decode
    // ==============================
    always_comb begin
        nxt          = '0;                      // Unknown opcodes become bubbles
        nxt.rs1      = rs1;
        nxt.rs2      = rs2;
        nxt.rd       = instr[11:7];
        nxt.pc       = if_id.pc;
        nxt.rs1_data = rf_read(rs1);
        nxt.rs2_data = rf_read(rs2);
        use_rs1      = 1'b0;
        use_rs2      = 1'b0;
        case (opcode)
            OPC_OP: begin
                nxt.reg_write = 1'b1;
                nxt.alu_op    = alu_decode(instr[14:12], instr[31:25] == F7_SUB);
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
            end
            OPC_OP_IMM: begin
                nxt.reg_write = 1'b1;
                nxt.alu_src   = 1'b1;
                nxt.alu_op    = alu_decode(instr[14:12], 1'b0);
                nxt.imm       = imm_i;
                use_rs1       = 1'b1;
            end
            OPC_LOAD: begin
                nxt.reg_write = 1'b1;
                nxt.mem_read  = 1'b1;
                nxt.alu_src   = 1'b1;           // Address is rs1 + imm
                nxt.imm       = imm_i;
                use_rs1       = 1'b1;
            end
            OPC_STORE: begin
                nxt.mem_write = 1'b1;
                nxt.alu_src   = 1'b1;
                nxt.imm       = imm_s;
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;           // Store data
            end
            OPC_BRANCH: begin
                nxt.branch    = 1'b1;
                nxt.bne       = (instr[14:12] == F3_BNE);
                nxt.imm       = imm_b;
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
            end
            OPC_JAL: begin
                nxt.reg_write = 1'b1;           // Link value made in execute
                nxt.jump      = 1'b1;
                nxt.imm       = imm_j;
            end
            default: ;
        endcase
    end

    // ==============================
    // Load-use hazard and ID/EX
    // ==============================
    assign stall = id_ex.mem_read && (id_ex.rd != '0) &&
                   ((use_rs1 && id_ex.rd == rs1) || (use_rs2 && id_ex.rd == rs2));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            id_ex <= '0;
        else if (stall || redirect)
            id_ex <= '0;                        // Bubble
        else
            id_ex <= nxt;
    end

    // The bubble behind a load clears the hazard on the next cycle
    assert property (@(posedge clk) disable iff (!arst_n) stall |=> !stall)
        else $error("load-use stall lasted two cycles");

endmodule

//--- design/rv_execute.sv
// Execute stage with forwarding, ALU, branch and jump resolution and EX/MEM register
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_execute
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,
    input  id_ex_t              id_ex,
    input  mem_wb_t             mem_wb,     // Second forwarding source
    output ex_mem_t             ex_mem,
    output logic                redirect,   // Taken branch or JAL
    output logic [`RV_XLEN-1:0] target
);

    fwd_sel_e            sel_a;
    fwd_sel_e            sel_b;
    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] rs2_val;           // Forwarded rs2, also store data
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_res;

    // ==============================
    // Forwarding
    // ==============================
    function automatic fwd_sel_e fwd_pick(input logic [`RV_REG_AW-1:0] idx);
        if (idx == '0)
            return FWD_REGFILE;
        if (ex_mem.reg_write && ex_mem.rd == idx)
            return FWD_FROM_MEM;            // Youngest producer wins
        if (mem_wb.reg_write && mem_wb.rd == idx)
            return FWD_FROM_WB;
        return FWD_REGFILE;
    endfunction

    function automatic logic [`RV_XLEN-1:0] fwd_data(input fwd_sel_e sel,
                                                     input logic [`RV_XLEN-1:0] rf);
        case (sel)
            FWD_FROM_MEM: return ex_mem.result;  // Never a load, decode stalls that
            FWD_FROM_WB:  return mem_wb.result;
            default:      return rf;
        endcase
    endfunction

    always_comb begin
        sel_a   = fwd_pick(id_ex.rs1);
        sel_b   = fwd_pick(id_ex.rs2);
        op_a    = fwd_data(sel_a, id_ex.rs1_data);
        rs2_val = fwd_data(sel_b, id_ex.rs2_data);
        op_b    = id_ex.alu_src ? id_ex.imm : rs2_val;
    end

    // ==============================
    // ALU
    // ==============================
    always_comb begin
        case (id_ex.alu_op)
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_XOR: alu_res = op_a ^ op_b;
            ALU_SLT: alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_res = op_a + op_b;
        endcase
    end

    // Branch compare uses forwarded registers, not the ALU
    assign redirect = id_ex.jump ||
                      (id_ex.branch && ((op_a == rs2_val) != id_ex.bne));
    assign target   = id_ex.pc + id_ex.imm;

    // ==============================
    // EX/MEM register
    // ==============================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            ex_mem <= '0;
        else
            ex_mem <= '{reg_write:  id_ex.reg_write,
                        mem_read:   id_ex.mem_read,
                        mem_write:  id_ex.mem_write,
                        rd:         id_ex.rd,
                        result:     id_ex.jump ? id_ex.pc + 'd4 : alu_res,  // JAL link
                        store_data: rs2_val};
    end

    // Decode squashes ID/EX on redirect, so it cannot repeat
    assert property (@(posedge clk) disable iff (!arst_n) redirect |=> !redirect)
        else $error("redirect high in two consecutive cycles");

endmodule

//--- design/rv_memory.sv
// Memory stage with word-addressed data memory, result select and MEM/WB register
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_memory
    import rv_pipe_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  ex_mem_t ex_mem,
    output mem_wb_t mem_wb
);

    logic [`RV_XLEN-1:0]    dmem [2**`RV_DMEM_AW];   // Word addressed
    logic [`RV_DMEM_AW-1:0] addr;
    logic [`RV_XLEN-1:0]    wb_val;                 // Value headed for writeback

    assign addr = ex_mem.result[`RV_DMEM_AW+1:2];   // Byte address to word index

    // ==============================
    // Data memory
    // ==============================
    always_ff @(posedge clk) begin
        if (ex_mem.mem_write)
            dmem[addr] <= ex_mem.store_data;
    end

    assign wb_val = ex_mem.mem_read ? dmem[addr] : ex_mem.result;

    // ==============================
    // MEM/WB register
    // ==============================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            mem_wb <= '0;
        else
            mem_wb <= '{reg_write: ex_mem.reg_write,
                        rd:        ex_mem.rd,
                        result:    wb_val};
    end

    // Load and store come from exclusive opcodes in decode
    assert property (@(posedge clk) disable iff (!arst_n)
                     !(ex_mem.mem_read && ex_mem.mem_write))
        else $error("load and store set together in EX/MEM");

endmodule

//--- design/rv_core.sv
// Five-stage RV32I subset core joining fetch, decode, execute and memory
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_core
    import rv_pipe_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     run,           // Low during program load
    input  prog_wr_t prog,
    output retire_t  retire
);

    if_id_t              if_id;
    id_ex_t              id_ex;
    ex_mem_t             ex_mem;
    mem_wb_t             mem_wb;
    logic                stall;     // Decode to fetch
    logic                redirect;  // Execute to fetch and decode
    logic [`RV_XLEN-1:0] target;

    rv_fetch u_fetch (
        .clk      (clk),
        .arst_n   (arst_n),
        .run      (run),
        .prog     (prog),
        .stall    (stall),
        .redirect (redirect),
        .target   (target),
        .if_id    (if_id)
    );

    rv_decode u_decode (
        .clk      (clk),
        .arst_n   (arst_n),
        .if_id    (if_id),
        .redirect (redirect),
        .mem_wb   (mem_wb),
        .stall    (stall),
        .id_ex    (id_ex)
    );

    rv_execute u_execute (
        .clk      (clk),
        .arst_n   (arst_n),
        .id_ex    (id_ex),
        .mem_wb   (mem_wb),
        .ex_mem   (ex_mem),
        .redirect (redirect),
        .target   (target)
    );

    rv_memory u_memory (
        .clk      (clk),
        .arst_n   (arst_n),
        .ex_mem   (ex_mem),
        .mem_wb   (mem_wb)
    );

    // Writeback is visible as a retire strobe
    assign retire = '{valid: mem_wb.reg_write && (mem_wb.rd != '0),
                      rd:    mem_wb.rd,
                      data:  mem_wb.result};

endmodule

//--- include/tb_rv_asm.svh
// Instruction encoders for the RV32I subset that the core testbench runs
`ifndef TB_RV_ASM_SVH
`define TB_RV_ASM_SVH

// ==============================
// Base formats
// ==============================
function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic logic [31:0] i_word(input opcode_e opc, input logic [2:0] f3,
                                       input logic [4:0] rd, rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] s_word(input logic [4:0] rs1, rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};   // SW only
endfunction

function automatic logic [31:0] b_word(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                       input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] j_word(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

// Shorthands
function automatic logic [31:0] addi_word(input logic [4:0] rd, rs1, input logic [11:0] imm);
    return i_word(OPC_OP_IMM, F3_ADD_SUB, rd, rs1, imm);
endfunction

function automatic logic [31:0] lw_word(input logic [4:0] rd, rs1, input logic [11:0] imm);
    return i_word(OPC_LOAD, F3_WORD, rd, rs1, imm);
endfunction

`endif

//--- tests/tb_rv_core.sv
// Testbench for the five-stage core with program loading, ISA model and retire checks
`timescale 1ns/1ps
`include "rv_cfg.svh"

module tb_rv_core
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
();

    `include "tb_rv_asm.svh"

    localparam int IMEM_WORDS     = 2**`RV_IMEM_AW;
    localparam int RETIRE_TIMEOUT = 500;       // Cycles per program
    localparam int MODEL_STEPS    = 1000;      // Bound on model execution
    localparam int DRAIN_CYCLES   = 6;         // Four stage hops plus margin

    typedef struct packed {
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   data;
    } exp_t;

    typedef struct packed {
        logic valid;                           // Retire seen at last negedge
        logic extra;                           // Nothing was expected
        exp_t want;
        exp_t got;
    } check_t;

    logic                clk = 1'b0;
    logic                arst_n;
    logic                run;
    prog_wr_t            prog;
    retire_t             retire;
    logic                idle;                 // No program started yet
    check_t              chk;
    exp_t                exp_q [$];            // Model retire order
    logic [31:0]         prog_buf [IMEM_WORDS];
    int                  prog_len;
    logic [31:0]         mregs [`RV_REG_COUNT]; // Model registers
    logic [31:0]         mdmem [2**`RV_DMEM_AW];
    logic [31:0]         rng = 32'h9648_f373;

    always #20 clk = ~clk;

    rv_core dut (
        .clk    (clk),
        .arst_n (arst_n),
        .run    (run),
        .prog   (prog),
        .retire (retire)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run aborted");
    endtask

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);               // xorshift32
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // ==============================
    // ISA reference model
    // ==============================
    function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic sub,
                                               input logic [31:0] a, b);
        case (f3)
            F3_ADD_SUB: return sub ? a - b : a + b;
            F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_XOR:     return a ^ b;
            F3_OR:      return a | b;
            F3_AND:     return a & b;
            default:    return 'x;
        endcase
    endfunction

    task automatic execute_program();
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] res;
        logic [31:0] addr;
        logic        wr;
        int          steps;
        pc    = `RV_RESET_PC;
        steps = 0;
        while (pc < prog_len * 4 && steps < MODEL_STEPS) begin
            w       = prog_buf[pc[`RV_IMEM_AW+1:2]];
            a       = mregs[w[19:15]];
            b       = mregs[w[24:20]];
            imm_i   = {{20{w[31]}}, w[31:20]};
            addr    = a + imm_i;
            next_pc = pc + 32'd4;
            wr      = 1'b1;
            res     = '0;
            steps++;
            case (w[6:0])
                OPC_OP:     res = alu_result(w[14:12], w[30], a, b);  // Bit 30 picks SUB
                OPC_OP_IMM: res = alu_result(w[14:12], 1'b0, a, imm_i);
                OPC_LOAD:   res = mdmem[addr[`RV_DMEM_AW+1:2]];
                OPC_STORE: begin
                    addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    mdmem[addr[`RV_DMEM_AW+1:2]] = b;
                    wr = 1'b0;
                end
                OPC_BRANCH: begin
                    wr = 1'b0;
                    if ((a == b) != (w[14:12] == F3_BNE))
                        next_pc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                end
                OPC_JAL: begin
                    res     = pc + 32'd4;             // Link
                    next_pc = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                end
                default: wr = 1'b0;
            endcase
            if (wr && w[11:7] != 5'd0) begin
                mregs[w[11:7]] = res;
                exp_q.push_back(exp_t'{rd: w[11:7], data: res});
            end
            pc = next_pc;
        end
        if (steps >= MODEL_STEPS)
            abort_run("The reference model never reached the end of the program");
    endtask

    // ==============================
    // Program building and running
    // ==============================
    task automatic emit(input logic [31:0] w);
        prog_buf[prog_len] = w;
        prog_len++;
    endtask

    task automatic load_program();
        for (int a = 0; a < IMEM_WORDS; a++) begin
            @(posedge clk);
            prog <= '{we: 1'b1, addr: a[`RV_IMEM_AW-1:0],
                      instr: (a < prog_len) ? prog_buf[a] : addi_word(5'd0, 5'd0, a[11:0])};
        end
        @(posedge clk);
        prog <= '0;
    endtask

    task automatic run_program(input string name);
        int cycles;
        execute_program();                     // Expected retires first
        load_program();
        @(posedge clk);
        run  <= 1'b1;
        idle <= 1'b0;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < RETIRE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() != 0)
            abort_run($sformatf("Retirement stalled in the %s program, %0d results missing",
                                name, exp_q.size()));
        @(posedge clk);
        run <= 1'b0;
        repeat (DRAIN_CYCLES) @(posedge clk);  // Late or squashed retires still caught
    endtask

    task automatic build_alu_program();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  prev1;
        logic [4:0]  prev2;
        prog_len = 0;
        for (int i = 1; i < `RV_REG_COUNT; i++) begin
            r = next_rand();
            emit(addi_word(i[4:0], 5'd0, r[11:0]));  // Seed every register
        end
        prev1 = 5'd31;
        prev2 = 5'd30;
        for (int i = 0; i < 28; i++) begin
            r  = next_rand();
            rd = 5'(1 + r[15:8] % 31);
            case (i % 7)                           // rs1 from EX/MEM, rs2 from MEM/WB
                0:       emit(r_word(7'd0, F3_ADD_SUB, rd, prev1, prev2));
                1:       emit(r_word(F7_SUB, F3_ADD_SUB, rd, prev1, prev2));
                2:       emit(r_word(7'd0, F3_AND, rd, prev1, prev2));
                3:       emit(r_word(7'd0, F3_OR, rd, prev1, prev2));
                4:       emit(r_word(7'd0, F3_XOR, rd, prev1, prev2));
                5:       emit(r_word(7'd0, F3_SLT, rd, prev1, prev2));
                default: emit(addi_word(rd, prev1, r[27:16]));
            endcase
            prev2 = prev1;
            prev1 = rd;
        end
    endtask

    task automatic build_memory_program();
        logic [31:0] r;
        prog_len = 0;
        for (int i = 0; i < 3; i++) begin
            r = next_rand();
            emit(addi_word(5'd5, 5'd0, {2'b00, r[7:0], 2'b00}));   // Word aligned base
            emit(addi_word(5'd6, 5'd0, r[27:16]));
            emit(s_word(5'd5, 5'd6, 12'd8));
            emit(lw_word(5'd7, 5'd5, 12'd8));
            emit(r_word(7'd0, F3_ADD_SUB, 5'd8, 5'd7, 5'd6));       // Load-use
        end
    endtask

    task automatic build_branch_program();
        prog_len = 0;
        emit(addi_word(5'd1, 5'd0, 12'd5));
        emit(addi_word(5'd2, 5'd0, 12'd5));
        emit(b_word(F3_BEQ, 5'd1, 5'd2, 13'd12));   // Taken
        emit(addi_word(5'd10, 5'd0, 12'd1));
        emit(addi_word(5'd11, 5'd0, 12'd2));
        emit(b_word(F3_BNE, 5'd1, 5'd2, 13'd12));   // Falls through
        emit(addi_word(5'd12, 5'd0, 12'd3));
        emit(addi_word(5'd3, 5'd0, 12'd7));
        emit(b_word(F3_BNE, 5'd1, 5'd3, 13'd12));   // Taken, x3 forwarded
        emit(addi_word(5'd13, 5'd0, 12'd4));
        emit(addi_word(5'd14, 5'd0, 12'd5));
        emit(b_word(F3_BEQ, 5'd1, 5'd3, 13'd12));
        emit(addi_word(5'd15, 5'd0, 12'd6));
    endtask

    task automatic build_jump_program();
        prog_len = 0;
        emit(j_word(5'd1, 21'd12));                 // Link into x1
        emit(addi_word(5'd20, 5'd0, 12'd1));
        emit(addi_word(5'd21, 5'd0, 12'd2));
        emit(addi_word(5'd22, 5'd1, 12'd0));        // Reads the link
        emit(j_word(5'd0, 21'd12));                 // No link
        emit(addi_word(5'd23, 5'd0, 12'd3));
        emit(addi_word(5'd24, 5'd0, 12'd4));
        emit(addi_word(5'd25, 5'd0, 12'd5));
    endtask

    // ==============================
    // Retire checking
    // ==============================
    always @(negedge clk) begin
        chk <= '0;
        if (arst_n && retire.valid) begin
            if (exp_q.size() == 0)
                chk <= '{valid: 1'b1, extra: 1'b1, want: '0, got: {retire.rd, retire.data}};
            else
                chk <= '{valid: 1'b1, extra: 1'b0, want: exp_q.pop_front(),
                         got: {retire.rd, retire.data}};
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) idle |-> !retire.valid)
        else abort_run("A result retired before any program was started");

    assert property (@(posedge clk) disable iff (!arst_n) chk.valid |-> !chk.extra)
        else abort_run($sformatf("An extra result retired into x%0d", chk.got.rd));

    assert property (@(posedge clk) disable iff (!arst_n)
                     chk.valid && !chk.extra |-> chk.want == chk.got)
        else abort_run($sformatf("MISMATCH at time %0t: expected x%0d = %h, got x%0d = %h",
                                 $time, chk.want.rd, chk.want.data, chk.got.rd, chk.got.data));

    initial begin
        arst_n <= 1'b0;
        run    <= 1'b0;
        prog   <= '0;
        idle   <= 1'b1;
        for (int i = 0; i < `RV_REG_COUNT; i++)
            mregs[i] = '0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        repeat (2) @(posedge clk);                  // Idle window with run low
        build_alu_program();
        run_program("ALU chain");
        build_memory_program();
        run_program("store and load");
        build_branch_program();
        run_program("branch");
        build_jump_program();
        run_program("jump");
        $display("Everything OK");
        $finish;
    end

endmodule

//--- build.f
+incdir+include
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_memory.sv
design/rv_core.sv
tests/tb_rv_core.sv
